/* design/csr_pkg.sv */
package csr_pkg;

  // widths
  localparam int XLEN       = 64;
  localparam int CSR_ADDR_W = 12;

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

  // machine CSR addresses
  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MIE     = 12'h304;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;
  localparam csr_addr_t CSR_MTVAL   = 12'h343;
  localparam csr_addr_t CSR_MIP     = 12'h344;

  // mstatus fields
  localparam int MSTATUS_MIE    = 3;
  localparam int MSTATUS_MPIE   = 7;
  localparam int MSTATUS_MPP_LO = 11;
  localparam int MSTATUS_MPP_HI = 12;

  // timer interrupt bits in mip / mie
  localparam int MIP_MTIP = 7;
  localparam int MIE_MTIE = 7;

  // UXL = SXL = 2, MPP = M
  localparam xlen_t MSTATUS_RESET = 64'h0000_000a_0000_1800;

  // machine timer interrupt cause
  localparam xlen_t MCAUSE_MTI = {1'b1, 63'd7};

  // encodings follow funct3[1:0] of csrrw / csrrs / csrrc
  typedef enum logic [1:0] {
    CSR_RW = 2'b01,
    CSR_RS = 2'b10,
    CSR_RC = 2'b11
  } csr_op_t;

  typedef enum logic [1:0] {
    TRAP_IDLE     = 2'b00,
    TRAP_REDIRECT = 2'b01
  } trap_state_t;

endpackage

/* design/csr_if.sv */
`timescale 1ns/1ns

// generic access port between the exec unit and the register file
interface csr_access_if;
  csr_pkg::csr_addr_t rd_addr;
  csr_pkg::csr_addr_t wr_addr;
  logic               wr_valid;
  csr_pkg::xlen_t     wr_data;
  csr_pkg::xlen_t     rd_data;
  logic               rd_hit;

  modport exec (output rd_addr, wr_addr, wr_valid, wr_data, input rd_data, rd_hit);
  modport regfile (input rd_addr, wr_addr, wr_valid, wr_data, output rd_data, rd_hit);
endinterface

// dedicated trap-side writes and register taps
interface csr_trap_if;
  csr_pkg::xlen_t mstatus_wdata;
  logic           mstatus_wvalid;
  csr_pkg::xlen_t mepc_wdata;
  logic           mepc_wvalid;
  csr_pkg::xlen_t mcause_wdata;
  logic           mcause_wvalid;
  csr_pkg::xlen_t mtval_wdata;
  logic           mtval_wvalid;
  csr_pkg::xlen_t mstatus_q;
  csr_pkg::xlen_t mepc_q;
  csr_pkg::xlen_t mtvec_q;
  csr_pkg::xlen_t mie_q;
  csr_pkg::xlen_t mip_q;

  modport trap (
    output mstatus_wdata, mstatus_wvalid, mepc_wdata, mepc_wvalid,
    output mcause_wdata, mcause_wvalid, mtval_wdata, mtval_wvalid,
    input  mstatus_q, mepc_q, mtvec_q, mie_q, mip_q
  );
  modport regfile (
    input  mstatus_wdata, mstatus_wvalid, mepc_wdata, mepc_wvalid,
    input  mcause_wdata, mcause_wvalid, mtval_wdata, mtval_wvalid,
    output mstatus_q, mepc_q, mtvec_q, mie_q, mip_q
  );
endinterface

/* design/csr_regfile.sv */
`timescale 1ns/1ns

module csr_regfile (
  input  logic          clk,
  input  logic          rst_n_i,
  input  logic          timer_irq_i,
  csr_access_if.regfile acc,
  csr_trap_if.regfile   trp
);

  csr_pkg::xlen_t mstatus_q;
  csr_pkg::xlen_t mepc_q;
  csr_pkg::xlen_t mcause_q;
  csr_pkg::xlen_t mtval_q;
  csr_pkg::xlen_t mtvec_q;
  csr_pkg::xlen_t mie_q;
  csr_pkg::xlen_t mip_q;

  csr_pkg::xlen_t mstatus_d;
  csr_pkg::xlen_t mip_d;

  logic gen_mstatus;
  logic gen_mepc;
  logic gen_mcause;
  logic gen_mtval;
  logic gen_mtvec;
  logic gen_mie;
  logic gen_mip;

  // address decode of the generic write
  always_comb begin
    gen_mstatus = 1'b0;
    gen_mepc    = 1'b0;
    gen_mcause  = 1'b0;
    gen_mtval   = 1'b0;
    gen_mtvec   = 1'b0;
    gen_mie     = 1'b0;
    gen_mip     = 1'b0;
    if (acc.wr_valid) begin
      case (acc.wr_addr)
        csr_pkg::CSR_MSTATUS: gen_mstatus = 1'b1;
        csr_pkg::CSR_MEPC:    gen_mepc    = 1'b1;
        csr_pkg::CSR_MCAUSE:  gen_mcause  = 1'b1;
        csr_pkg::CSR_MTVAL:   gen_mtval   = 1'b1;
        csr_pkg::CSR_MTVEC:   gen_mtvec   = 1'b1;
        csr_pkg::CSR_MIE:     gen_mie     = 1'b1;
        csr_pkg::CSR_MIP:     gen_mip     = 1'b1;
        default: ;
      endcase
    end
  end

  // trap write beats the generic one and MPP stays pinned to M
  always_comb begin
    mstatus_d = mstatus_q;
    if (trp.mstatus_wvalid)
      mstatus_d = trp.mstatus_wdata;
    else if (gen_mstatus)
      mstatus_d = acc.wr_data;
    mstatus_d[csr_pkg::MSTATUS_MPP_HI:csr_pkg::MSTATUS_MPP_LO] = 2'b11;
  end

  // MTIP mirrors the timer line every cycle
  always_comb begin
    mip_d = gen_mip ? acc.wr_data : mip_q;
    mip_d[csr_pkg::MIP_MTIP] = timer_irq_i;
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      mstatus_q <= csr_pkg::MSTATUS_RESET;
      mepc_q    <= '0;
      mcause_q  <= '0;
      mtval_q   <= '0;
      mtvec_q   <= '0;
      mie_q     <= '0;
      mip_q     <= '0;
    end else begin
      mstatus_q <= mstatus_d;
      mip_q     <= mip_d;
      if (trp.mepc_wvalid || gen_mepc)
        mepc_q <= trp.mepc_wvalid ? trp.mepc_wdata : acc.wr_data;
      if (trp.mcause_wvalid || gen_mcause)
        mcause_q <= trp.mcause_wvalid ? trp.mcause_wdata : acc.wr_data;
      if (trp.mtval_wvalid || gen_mtval)
        mtval_q <= trp.mtval_wvalid ? trp.mtval_wdata : acc.wr_data;
      if (gen_mtvec)
        mtvec_q <= acc.wr_data;
      if (gen_mie)
        mie_q <= acc.wr_data;
    end
  end

  // combinational read port
  always_comb begin
    acc.rd_hit = 1'b1;
    case (acc.rd_addr)
      csr_pkg::CSR_MSTATUS: acc.rd_data = mstatus_q;
      csr_pkg::CSR_MEPC:    acc.rd_data = mepc_q;
      csr_pkg::CSR_MCAUSE:  acc.rd_data = mcause_q;
      csr_pkg::CSR_MTVAL:   acc.rd_data = mtval_q;
      csr_pkg::CSR_MTVEC:   acc.rd_data = mtvec_q;
      csr_pkg::CSR_MIE:     acc.rd_data = mie_q;
      csr_pkg::CSR_MIP:     acc.rd_data = mip_q;
      default: begin
        acc.rd_data = '0;
        acc.rd_hit  = 1'b0;
      end
    endcase
  end

  // register taps for the trap unit
  assign trp.mstatus_q = mstatus_q;
  assign trp.mepc_q    = mepc_q;
  assign trp.mtvec_q   = mtvec_q;
  assign trp.mie_q     = mie_q;
  assign trp.mip_q     = mip_q;

  // a generic write needs a hit on the address being read
  a_write_on_hit: assert property (@(posedge clk) disable iff (!rst_n_i)
    acc.wr_valid |-> acc.rd_hit && acc.wr_addr == acc.rd_addr);

endmodule

/* design/csr_exec_unit.sv */
`timescale 1ns/1ns

module csr_exec_unit (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  csr_pkg::csr_op_t   req_op_i,
  input  csr_pkg::csr_addr_t req_addr_i,
  input  csr_pkg::xlen_t     req_wdata_i,
  output logic               rsp_valid_o,
  input  logic               rsp_ready_i,
  output csr_pkg::xlen_t     rsp_rdata_o,
  output logic               rsp_illegal_o,
  csr_access_if.exec         acc
);

  logic           accept;
  logic           rsp_valid_q;
  csr_pkg::xlen_t rsp_rdata_q;
  logic           rsp_illegal_q;
  csr_pkg::xlen_t new_val;

  // slot frees up when the pending response is taken
  assign req_ready_o = !rsp_valid_q || rsp_ready_i;
  assign accept      = req_valid_i && req_ready_o;

  // read and write share one address
  assign acc.rd_addr = req_addr_i;
  assign acc.wr_addr = req_addr_i;

  always_comb begin
    case (req_op_i)
      csr_pkg::CSR_RW: new_val = req_wdata_i;
      csr_pkg::CSR_RS: new_val = acc.rd_data | req_wdata_i;
      csr_pkg::CSR_RC: new_val = acc.rd_data & ~req_wdata_i;
      default:         new_val = acc.rd_data;
    endcase
  end

  // no write to an unimplemented address
  assign acc.wr_valid = accept && acc.rd_hit;
  assign acc.wr_data  = new_val;

  always_ff @(posedge clk) begin
    if (!rst_n_i)
      rsp_valid_q <= 1'b0;
    else if (accept)
      rsp_valid_q <= 1'b1;
    else if (rsp_ready_i)
      rsp_valid_q <= 1'b0;
  end

  // response payload, held until the next acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      rsp_rdata_q   <= acc.rd_data;
      rsp_illegal_q <= !acc.rd_hit;
    end
  end

  assign rsp_valid_o   = rsp_valid_q;
  assign rsp_rdata_o   = rsp_rdata_q;
  assign rsp_illegal_o = rsp_illegal_q;

  a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    rsp_valid_o && !rsp_ready_i |=>
      rsp_valid_o && $stable(rsp_rdata_o) && $stable(rsp_illegal_o));

endmodule

/* design/trap_unit.sv */
`timescale 1ns/1ns

module trap_unit (
  input  logic           clk,
  input  logic           rst_n_i,
  input  logic           trap_valid_i,
  input  csr_pkg::xlen_t trap_cause_i,
  input  csr_pkg::xlen_t trap_pc_i,
  input  csr_pkg::xlen_t trap_tval_i,
  input  logic           mret_valid_i,
  output logic           redirect_valid_o,
  output csr_pkg::xlen_t redirect_pc_o,
  output logic           irq_pending_o,
  csr_trap_if.trap       trp
);

  csr_pkg::trap_state_t state_q;
  csr_pkg::trap_state_t state_d;
  csr_pkg::xlen_t       redirect_pc_q;
  csr_pkg::xlen_t       target;
  logic                 pulse;

  assign pulse = trap_valid_i || mret_valid_i;

  // trap entry writes the cause/pc/tval triple
  assign trp.mepc_wvalid   = trap_valid_i;
  assign trp.mepc_wdata    = trap_pc_i;
  assign trp.mcause_wvalid = trap_valid_i;
  assign trp.mcause_wdata  = trap_cause_i;
  assign trp.mtval_wvalid  = trap_valid_i;
  assign trp.mtval_wdata   = trap_tval_i;

  // MIE/MPIE shuffle
  always_comb begin
    trp.mstatus_wdata  = trp.mstatus_q;
    trp.mstatus_wvalid = pulse;
    if (trap_valid_i) begin
      trp.mstatus_wdata[csr_pkg::MSTATUS_MPIE] = trp.mstatus_q[csr_pkg::MSTATUS_MIE];
      trp.mstatus_wdata[csr_pkg::MSTATUS_MIE]  = 1'b0;
    end else if (mret_valid_i) begin
      trp.mstatus_wdata[csr_pkg::MSTATUS_MIE]  = trp.mstatus_q[csr_pkg::MSTATUS_MPIE];
      trp.mstatus_wdata[csr_pkg::MSTATUS_MPIE] = 1'b1;
    end
    // only M mode exists
    trp.mstatus_wdata[csr_pkg::MSTATUS_MPP_HI:csr_pkg::MSTATUS_MPP_LO] = 2'b11;
  end

  // direct mode only so the low bits of mtvec are dropped
  assign target = trap_valid_i ? {trp.mtvec_q[csr_pkg::XLEN-1:2], 2'b00} : trp.mepc_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      csr_pkg::TRAP_IDLE:
        if (pulse) state_d = csr_pkg::TRAP_REDIRECT;
      csr_pkg::TRAP_REDIRECT:
        state_d = pulse ? csr_pkg::TRAP_REDIRECT : csr_pkg::TRAP_IDLE;
      default:
        state_d = csr_pkg::TRAP_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i)
      state_q <= csr_pkg::TRAP_IDLE;
    else
      state_q <= state_d;
  end

  always_ff @(posedge clk) begin
    if (pulse)
      redirect_pc_q <= target;
  end

  assign redirect_valid_o = (state_q == csr_pkg::TRAP_REDIRECT);
  assign redirect_pc_o    = redirect_pc_q;

  assign irq_pending_o = trp.mstatus_q[csr_pkg::MSTATUS_MIE] &
                         trp.mie_q[csr_pkg::MIE_MTIE] &
                         trp.mip_q[csr_pkg::MIP_MTIP];

  a_pulse_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(trap_valid_i && mret_valid_i));

endmodule

/* design/csr_top.sv */
`timescale 1ns/1ns

module csr_top (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  csr_pkg::csr_op_t   req_op_i,
  input  csr_pkg::csr_addr_t req_addr_i,
  input  csr_pkg::xlen_t     req_wdata_i,
  output logic               rsp_valid_o,
  input  logic               rsp_ready_i,
  output csr_pkg::xlen_t     rsp_rdata_o,
  output logic               rsp_illegal_o,
  input  logic               trap_valid_i,
  input  csr_pkg::xlen_t     trap_cause_i,
  input  csr_pkg::xlen_t     trap_pc_i,
  input  csr_pkg::xlen_t     trap_tval_i,
  input  logic               mret_valid_i,
  output logic               redirect_valid_o,
  output csr_pkg::xlen_t     redirect_pc_o,
  output logic               irq_pending_o,
  input  logic               timer_irq_i
);

  csr_access_if acc_if ();
  csr_trap_if   trp_if ();

  csr_regfile u_regfile (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .timer_irq_i (timer_irq_i),
    .acc         (acc_if.regfile),
    .trp         (trp_if.regfile)
  );

  csr_exec_unit u_exec (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_op_i      (req_op_i),
    .req_addr_i    (req_addr_i),
    .req_wdata_i   (req_wdata_i),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_ready_i   (rsp_ready_i),
    .rsp_rdata_o   (rsp_rdata_o),
    .rsp_illegal_o (rsp_illegal_o),
    .acc           (acc_if.exec)
  );

  trap_unit u_trap (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .trap_valid_i     (trap_valid_i),
    .trap_cause_i     (trap_cause_i),
    .trap_pc_i        (trap_pc_i),
    .trap_tval_i      (trap_tval_i),
    .mret_valid_i     (mret_valid_i),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o),
    .irq_pending_o    (irq_pending_o),
    .trp              (trp_if.trap)
  );

endmodule

/* verification/csr_tb.sv */
`timescale 1ns/1ns

module csr_tb;

  logic               clk;
  logic               rst_n_i;
  logic               req_valid_i;
  logic               req_ready_o;
  csr_pkg::csr_op_t   req_op_i;
  csr_pkg::csr_addr_t req_addr_i;
  csr_pkg::xlen_t     req_wdata_i;
  logic               rsp_valid_o;
  logic               rsp_ready_i;
  csr_pkg::xlen_t     rsp_rdata_o;
  logic               rsp_illegal_o;
  logic               trap_valid_i;
  csr_pkg::xlen_t     trap_cause_i;
  csr_pkg::xlen_t     trap_pc_i;
  csr_pkg::xlen_t     trap_tval_i;
  logic               mret_valid_i;
  logic               redirect_valid_o;
  csr_pkg::xlen_t     redirect_pc_o;
  logic               irq_pending_o;
  logic               timer_irq_i;

  // shadow CSRs indexed by CSR address
  csr_pkg::xlen_t     shadow [0:4095];
  csr_pkg::csr_addr_t csr_list [7];
  logic [64:0]        exp_q [$];
  logic [64:0]        exp_item;
  logic               hold_pending;
  csr_pkg::xlen_t     hold_rdata;
  logic               hold_illegal;
  logic               redir_due;
  csr_pkg::xlen_t     redir_exp;
  logic               bp_mode;
  int                 n_acc;
  int                 n_rsp;
  int                 n_checks;
  int                 errors;
  int                 err_mark;
  int                 n_tests;

  csr_top UUT (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic logic is_csr(input csr_pkg::csr_addr_t addr);
    return addr == csr_pkg::CSR_MSTATUS || addr == csr_pkg::CSR_MIE ||
           addr == csr_pkg::CSR_MTVEC || addr == csr_pkg::CSR_MEPC ||
           addr == csr_pkg::CSR_MCAUSE || addr == csr_pkg::CSR_MTVAL ||
           addr == csr_pkg::CSR_MIP;
  endfunction

  // expected new value of a csrrw / csrrs / csrrc
  function automatic csr_pkg::xlen_t ref_csr(input csr_pkg::csr_op_t op,
                                             input csr_pkg::csr_addr_t addr,
                                             input csr_pkg::xlen_t old,
                                             input csr_pkg::xlen_t wdata,
                                             input logic timer);
    csr_pkg::xlen_t nv;
    case (op)
      csr_pkg::CSR_RW: nv = wdata;
      csr_pkg::CSR_RS: nv = old | wdata;
      default:         nv = old & ~wdata;
    endcase
    if (addr == csr_pkg::CSR_MSTATUS)
      nv[csr_pkg::MSTATUS_MPP_HI:csr_pkg::MSTATUS_MPP_LO] = 2'b11;
    if (addr == csr_pkg::CSR_MIP)
      nv[csr_pkg::MIP_MTIP] = timer;
    return nv;
  endfunction

  // mstatus after trap entry or mret
  function automatic csr_pkg::xlen_t ref_trap_mstatus(input csr_pkg::xlen_t old,
                                                      input logic is_mret);
    csr_pkg::xlen_t nv;
    nv = old;
    if (is_mret) begin
      nv[csr_pkg::MSTATUS_MIE]  = old[csr_pkg::MSTATUS_MPIE];
      nv[csr_pkg::MSTATUS_MPIE] = 1'b1;
    end else begin
      nv[csr_pkg::MSTATUS_MPIE] = old[csr_pkg::MSTATUS_MIE];
      nv[csr_pkg::MSTATUS_MIE]  = 1'b0;
    end
    nv[csr_pkg::MSTATUS_MPP_HI:csr_pkg::MSTATUS_MPP_LO] = 2'b11;
    return nv;
  endfunction

  task automatic check_val(input string sig, input csr_pkg::xlen_t exp,
                           input csr_pkg::xlen_t act);
    n_checks++;
    assert (exp === act) else begin
      $display("Mismatch at %0t: %s expected %h, got %h", $time, sig, exp, act);
      errors++;
    end
  endtask

  // compare process samples at the edge before any input or flop update
  always @(posedge clk) begin
    if (!rst_n_i) begin
      foreach (csr_list[i])
        shadow[csr_list[i]] = '0;
      shadow[csr_pkg::CSR_MSTATUS] = csr_pkg::MSTATUS_RESET;
      exp_q.delete();
      hold_pending = 1'b0;
      redir_due    = 1'b0;
    end else begin
      if (hold_pending) begin
        check_val("rsp_valid_o", 64'd1, {63'd0, rsp_valid_o});
        check_val("rsp_rdata_o", hold_rdata, rsp_rdata_o);
        check_val("rsp_illegal_o", {63'd0, hold_illegal}, {63'd0, rsp_illegal_o});
      end
      // one item in flight, valid one cycle after acceptance
      check_val("rsp_valid_o", {63'd0, (exp_q.size() != 0)}, {63'd0, rsp_valid_o});
      check_val("req_ready_o", {63'd0, (exp_q.size() == 0 || rsp_ready_i)},
                {63'd0, req_ready_o});
      hold_pending = rsp_valid_o && !rsp_ready_i;
      hold_rdata   = rsp_rdata_o;
      hold_illegal = rsp_illegal_o;
      if (rsp_valid_o && rsp_ready_i) begin
        n_rsp++;
        assert (exp_q.size() != 0) else begin
          $display("response at %0t arrived with no request outstanding", $time);
          errors++;
        end
        if (exp_q.size() != 0) begin
          exp_item = exp_q.pop_front();
          check_val("rsp_rdata_o", exp_item[63:0], rsp_rdata_o);
          check_val("rsp_illegal_o", {63'd0, exp_item[64]}, {63'd0, rsp_illegal_o});
        end
      end
      check_val("redirect_valid_o", {63'd0, redir_due}, {63'd0, redirect_valid_o});
      if (redir_due)
        check_val("redirect_pc_o", redir_exp, redirect_pc_o);
      check_val("irq_pending_o",
                {63'd0, shadow[csr_pkg::CSR_MSTATUS][csr_pkg::MSTATUS_MIE] &
                        shadow[csr_pkg::CSR_MIE][csr_pkg::MIE_MTIE] &
                        shadow[csr_pkg::CSR_MIP][csr_pkg::MIP_MTIP]},
                {63'd0, irq_pending_o});
      if (req_valid_i && req_ready_o) begin
        if (is_csr(req_addr_i)) begin
          exp_q.push_back({1'b0, shadow[req_addr_i]});
          shadow[req_addr_i] = ref_csr(req_op_i, req_addr_i, shadow[req_addr_i],
                                       req_wdata_i, timer_irq_i);
        end else begin
          exp_q.push_back({1'b1, 64'd0});
        end
        n_acc++;
      end
      redir_due = trap_valid_i || mret_valid_i;
      if (trap_valid_i) begin
        redir_exp = {shadow[csr_pkg::CSR_MTVEC][63:2], 2'b00};
        shadow[csr_pkg::CSR_MEPC]    = trap_pc_i;
        shadow[csr_pkg::CSR_MCAUSE]  = trap_cause_i;
        shadow[csr_pkg::CSR_MTVAL]   = trap_tval_i;
        shadow[csr_pkg::CSR_MSTATUS] = ref_trap_mstatus(shadow[csr_pkg::CSR_MSTATUS], 1'b0);
      end else if (mret_valid_i) begin
        redir_exp = shadow[csr_pkg::CSR_MEPC];
        shadow[csr_pkg::CSR_MSTATUS] = ref_trap_mstatus(shadow[csr_pkg::CSR_MSTATUS], 1'b1);
      end
      // MTIP follows the timer line one edge later
      shadow[csr_pkg::CSR_MIP][csr_pkg::MIP_MTIP] = timer_irq_i;
    end
  end

  // random back-pressure on the response channel
  always @(posedge clk)
    rsp_ready_i <= bp_mode ? ($urandom % 2 == 1) : 1'b1;

  task automatic send_req(input csr_pkg::csr_op_t op, input csr_pkg::csr_addr_t addr,
                          input csr_pkg::xlen_t wdata);
    req_valid_i <= 1'b1;
    req_op_i    <= op;
    req_addr_i  <= addr;
    req_wdata_i <= wdata;
    do @(posedge clk); while (!req_ready_o);
    req_valid_i <= 1'b0;
  endtask

  task automatic drain();
    do @(negedge clk); while (exp_q.size() != 0);
    @(posedge clk);
  endtask

  task automatic rand_req();
    csr_pkg::csr_addr_t addr;
    csr_pkg::xlen_t     wdata;
    csr_pkg::csr_op_t   op;
    addr  = csr_list[$urandom % 7];
    wdata = {$urandom, $urandom};
    case ($urandom % 3)
      0:       op = csr_pkg::CSR_RW;
      1:       op = csr_pkg::CSR_RS;
      default: op = csr_pkg::CSR_RC;
    endcase
    // keep mip bit 7 out of the generic writes
    if (addr == csr_pkg::CSR_MIP)
      wdata[csr_pkg::MIP_MTIP] = 1'b0;
    send_req(op, addr, wdata);
  endtask

  task automatic read_all();
    foreach (csr_list[i])
      send_req(csr_pkg::CSR_RS, csr_list[i], '0);
  endtask

  task automatic end_test(input string name);
    n_tests++;
    $display("[%0t] test %s %s, %0d new errors", $time, name,
             (errors == err_mark) ? "pass" : "fail", errors - err_mark);
    err_mark = errors;
  endtask

  initial begin
    int budget;
    // reset, fixed tests, 200 random ops, 60 back-pressured ops, margin x2
    budget = 4 + 40 + 200 * 2 + 60 * 6 + 3 * 40;
    #(budget * 4 * 2);
    $display("watchdog expired at %0t, the run did not complete", $time);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'hf210));
    csr_list = '{csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MIE, csr_pkg::CSR_MTVEC,
                 csr_pkg::CSR_MEPC, csr_pkg::CSR_MCAUSE, csr_pkg::CSR_MTVAL,
                 csr_pkg::CSR_MIP};
    rst_n_i      = 1'b0;
    req_valid_i  = 1'b0;
    req_op_i     = csr_pkg::CSR_RS;
    req_addr_i   = '0;
    req_wdata_i  = '0;
    rsp_ready_i  = 1'b1;
    trap_valid_i = 1'b0;
    trap_cause_i = '0;
    trap_pc_i    = '0;
    trap_tval_i  = '0;
    mret_valid_i = 1'b0;
    timer_irq_i  = 1'b0;
    bp_mode      = 1'b0;
    n_acc = 0;
    n_rsp = 0;
    n_checks = 0;
    errors = 0;
    err_mark = 0;
    n_tests = 0;
    repeat (4) @(posedge clk);
    rst_n_i <= 1'b1;

    read_all();
    send_req(csr_pkg::CSR_RW, 12'h7c0, {$urandom, $urandom});
    read_all();
    drain();
    end_test("reset_values");

    repeat (200) rand_req();
    drain();
    end_test("rmw_random");

    bp_mode <= 1'b1;
    repeat (60) rand_req();
    drain();
    bp_mode <= 1'b0;
    check_val("response count", n_acc, n_rsp);
    end_test("backpressure");

    send_req(csr_pkg::CSR_RW, csr_pkg::CSR_MTVEC, {$urandom, $urandom});
    send_req(csr_pkg::CSR_RS, csr_pkg::CSR_MSTATUS, 64'h8);
    drain();
    trap_valid_i <= 1'b1;
    trap_cause_i <= {$urandom, $urandom};
    trap_pc_i    <= {$urandom, $urandom};
    trap_tval_i  <= {$urandom, $urandom};
    @(posedge clk);
    trap_valid_i <= 1'b0;
    // redirect is due exactly one cycle after the pulse
    @(posedge clk);
    read_all();
    drain();
    end_test("trap_entry");

    send_req(csr_pkg::CSR_RW, csr_pkg::CSR_MEPC, {$urandom, $urandom});
    drain();
    mret_valid_i <= 1'b1;
    @(posedge clk);
    mret_valid_i <= 1'b0;
    @(posedge clk);
    read_all();
    drain();
    end_test("mret");

    send_req(csr_pkg::CSR_RW, csr_pkg::CSR_MIE, 64'h80);
    send_req(csr_pkg::CSR_RS, csr_pkg::CSR_MSTATUS, 64'h8);
    drain();
    timer_irq_i <= 1'b1;
    do @(posedge clk); while (!irq_pending_o);
    send_req(csr_pkg::CSR_RS, csr_pkg::CSR_MIP, '0);
    send_req(csr_pkg::CSR_RC, csr_pkg::CSR_MSTATUS, 64'h8);
    send_req(csr_pkg::CSR_RS, csr_pkg::CSR_MSTATUS, 64'h8);
    drain();
    timer_irq_i <= 1'b0;
    repeat (3) @(posedge clk);
    send_req(csr_pkg::CSR_RS, csr_pkg::CSR_MIP, '0);
    drain();
    end_test("timer_irq");

    $display("tests %0d, checks %0d, responses %0d, errors %0d",
             n_tests, n_checks, n_rsp, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

/* vlog.f */
design/csr_pkg.sv
design/csr_if.sv
design/csr_regfile.sv
design/csr_exec_unit.sv
design/trap_unit.sv
design/csr_top.sv
verification/csr_tb.sv
